//--- compile.f
+incdir+logic
logic/spdif_pkg.sv
logic/byte_fifo.sv
logic/sample_assembler.sv
logic/biphase_encoder.sv
logic/spdif_tx.sv
test/spdif_tx_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
LINT     = --lint-only --timing
TOP      = spdif_tx_tb
RTL_TOP  = spdif_tx
FILELIST = compile.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/spdif_tx_tb.sv
`timescale 1ns/10ps

`include "spdif_defines.svh"

module spdif_tx_tb;

    // Preamble codes as the monitor reports them.
    localparam logic [1:0] PRE_B   = 2'd0;
    localparam logic [1:0] PRE_M   = 2'd1;
    localparam logic [1:0] PRE_W   = 2'd2;
    localparam logic [1:0] PRE_BAD = 2'd3;
    localparam int WAIT_LIMIT = 200;

    logic                     byte_clk_i;
    logic                     reset_i;
    logic [1:0]               bit_depth_i;
    logic                     wr_en_i;
    logic [`SPDIF_BYTE_W-1:0] wr_data_i;
    logic                     full_o;
    logic                     streaming_o;
    logic                     spdif_o;

    logic [31:0] lcg_state = 32'hc91f_85bd;

    // Line monitor state, cell 0 in bit 0.
    logic [63:0] cell_buf = '0;
    logic [5:0]  cell_cnt = '0;
    logic        prev_level = 1'b1;

    spdif_pkg::subframe_u exp_q[$];
    spdif_pkg::subframe_u dec_q[$];
    logic [1:0]           pre_q[$];

    spdif_tx uut (
        .byte_clk_i  (byte_clk_i),
        .reset_i     (reset_i),
        .bit_depth_i (bit_depth_i),
        .wr_en_i     (wr_en_i),
        .wr_data_i   (wr_data_i),
        .full_o      (full_o),
        .streaming_o (streaming_o),
        .spdif_o     (spdif_o)
    );

    initial begin
        byte_clk_i = 1'b0;
        forever #20 byte_clk_i = ~byte_clk_i;
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic spdif_pkg::subframe_u expected_word(logic [23:0] sample, logic depth16);
        spdif_pkg::subframe_u w;
        w.raw = '0;
        // Top byte is unused at 16 bits.
        w.fields.audio  = depth16 ? {8'h00, sample[15:0]} : sample;
        w.fields.parity = ^w.fields.audio;
        return w;
    endfunction

    // B opens each block, then left is M and right is W.
    function automatic logic [1:0] expected_preamble(int idx);
        if ((idx % `SPDIF_BLOCK_SUBFRAMES) == 0) begin
            return PRE_B;
        end
        return (idx % 2 == 1) ? PRE_W : PRE_M;
    endfunction

    // Either polarity is a valid preamble.
    function automatic logic [1:0] classify_preamble(logic [63:0] cells);
        logic [7:0] pre;
        pre = {cells[0], cells[1], cells[2], cells[3], cells[4], cells[5], cells[6], cells[7]};
        if (pre == `SPDIF_PRE_B || pre == ~(`SPDIF_PRE_B)) return PRE_B;
        if (pre == `SPDIF_PRE_M || pre == ~(`SPDIF_PRE_M)) return PRE_M;
        if (pre == `SPDIF_PRE_W || pre == ~(`SPDIF_PRE_W)) return PRE_W;
        return PRE_BAD;
    endfunction

    function automatic spdif_pkg::subframe_u decode_cells(logic [63:0] cells);
        spdif_pkg::subframe_u w;
        logic [63:0] sh;
        logic [27:0] bits;
        int k;
        bits = '0;
        for (k = 0; k < 28; k++) begin
            sh = cells >> (8 + 2 * k);
            // Mid-bit transition means a one, first bit ends up at the bottom.
            bits = {sh[0] ^ sh[1], bits[27:1]};
        end
        w.fields.audio          = bits[23:0];
        w.fields.validity       = bits[24];
        w.fields.user           = bits[25];
        w.fields.channel_status = bits[26];
        w.fields.parity         = bits[27];
        w.fields.pad            = 4'd0;
        return w;
    endfunction

    // ==============================
    // Checks
    // ==============================

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(string name, spdif_pkg::subframe_u exp, spdif_pkg::subframe_u act);
        if (act.raw !== exp.raw) begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp.raw, act.raw);
            stop_on_error();
        end
    endtask

    task automatic check_bit(string name, logic act, logic exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_preamble(string name, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    // Line monitor, outputs are stable at the falling edge.
    always @(negedge byte_clk_i) begin
        if (streaming_o) begin
            // Preamble and every data bit open with a transition.
            if (cell_cnt == 6'd0 || (cell_cnt >= 6'd8 && !cell_cnt[0])) begin
                check_bit("spdif_o cell transition", spdif_o, ~prev_level);
            end
            cell_buf = {spdif_o, cell_buf[63:1]};
            if (cell_cnt == 6'(`SPDIF_CELLS - 1)) begin
                dec_q.push_back(decode_cells(cell_buf));
                pre_q.push_back(classify_preamble(cell_buf));
            end
            cell_cnt = cell_cnt + 6'd1;
        end else begin
            cell_cnt = 6'd0;
        end
        prev_level = spdif_o;
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic write_byte(input logic [7:0] b);
        int cycles;
        cycles = 0;
        while (full_o) begin
            @(negedge byte_clk_i);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: the FIFO stayed full and a byte could not be written.");
                stop_on_error();
            end
        end
        wr_en_i   = 1'b1;
        wr_data_i = b;
        @(negedge byte_clk_i);
        wr_en_i   = 1'b0;
    endtask

    task automatic collect_and_check(input logic depth16, input int n);
        spdif_pkg::subframe_u w;
        int cycles;
        int i;
        cycles = 0;
        while (dec_q.size() < n) begin
            @(posedge byte_clk_i);
            cycles++;
            if (cycles > n * `SPDIF_CELLS + 1000) begin
                $display("Timeout: only %0d of %0d sub-frames seen on the line.", dec_q.size(), n);
                stop_on_error();
            end
        end
        for (i = 0; i < n; i++) begin
            w = dec_q[i];
            check_bit("sub-frame parity over bits 31..4", ^w.raw[31:4], 1'b0);
            // At 16 bits the top audio byte carries nothing.
            if (depth16) begin
                check_bit("audio top byte zero", |w.fields.audio[23:16], 1'b0);
            end
            check_word("sub-frame word", exp_q[i], w);
            check_preamble("preamble code", expected_preamble(i), pre_q[i]);
        end
        // With no sample left the line stops and goes idle high.
        @(negedge byte_clk_i);
        cycles = 0;
        while (streaming_o || !spdif_o) begin
            @(negedge byte_clk_i);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timeout: the stream did not stop or the line did not return high.");
                stop_on_error();
            end
        end
    endtask

    task automatic stream_samples(input logic depth16, input int n);
        logic [31:0] r;
        int i;
        exp_q.delete();
        dec_q.delete();
        pre_q.delete();
        bit_depth_i = depth16 ? `SPDIF_DEPTH_16 : `SPDIF_DEPTH_24;
        for (i = 0; i < n; i++) begin
            r = lcg_next();
            exp_q.push_back(expected_word(r[31:8], depth16));
            // MSB first.
            if (!depth16) begin
                write_byte(r[31:24]);
            end
            write_byte(r[23:16]);
            write_byte(r[15:8]);
        end
        collect_and_check(depth16, n);
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_reset_state();
        @(negedge byte_clk_i);
        check_bit("spdif_o", spdif_o, 1'b1);
        check_bit("streaming_o", streaming_o, 1'b0);
        check_bit("full_o", full_o, 1'b0);
    endtask

    task automatic test_stream_24();
        stream_samples(1'b0, 8);
    endtask

    task automatic test_stream_16();
        stream_samples(1'b1, 8);
    endtask

    // Crosses one block boundary.
    task automatic test_preamble_order();
        stream_samples(1'b1, `SPDIF_BLOCK_SUBFRAMES + 2);
    endtask

    task automatic test_back_pressure();
        logic [7:0]  byte_q[$];
        logic [31:0] r;
        int i;
        exp_q.delete();
        dec_q.delete();
        pre_q.delete();
        // Invalid depth holds the assembler, so the FIFO fills.
        bit_depth_i = 2'd2;
        for (i = 0; i < 6; i++) begin
            r = lcg_next();
            exp_q.push_back(expected_word(r[31:8], 1'b0));
            byte_q.push_back(r[31:24]);
            byte_q.push_back(r[23:16]);
            byte_q.push_back(r[15:8]);
        end
        for (i = 0; i < 16; i++) begin
            write_byte(byte_q[i]);
        end
        check_bit("full_o", full_o, 1'b1);
        check_bit("streaming_o", streaming_o, 1'b0);
        // This byte is lost and must not show up on the line.
        wr_en_i   = 1'b1;
        wr_data_i = 8'h5a;
        @(negedge byte_clk_i);
        wr_en_i   = 1'b0;
        check_bit("full_o", full_o, 1'b1);
        bit_depth_i = `SPDIF_DEPTH_24;
        write_byte(byte_q[16]);
        write_byte(byte_q[17]);
        collect_and_check(1'b0, 6);
    endtask

    initial begin
        reset_i     = 1'b1;
        bit_depth_i = `SPDIF_DEPTH_24;
        wr_en_i     = 1'b0;
        wr_data_i   = '0;
        repeat (8) @(posedge byte_clk_i);
        @(negedge byte_clk_i);
        reset_i = 1'b0;
        test_reset_state();
        test_stream_24();
        test_stream_16();
        test_preamble_order();
        test_back_pressure();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- logic/spdif_tx.sv
`timescale 1ns/10ps

`include "spdif_defines.svh"

module spdif_tx (
    input  logic                     byte_clk_i,
    input  logic                     reset_i,
    // Stream setup.
    input  logic [1:0]               bit_depth_i,
    // Audio byte input.
    input  logic                     wr_en_i,
    input  logic [`SPDIF_BYTE_W-1:0] wr_data_i,
    output logic                     full_o,
    // Line output.
    output logic                     streaming_o,
    output logic                     spdif_o
);

    // ==============================
    // Internal links
    // ==============================

    // FIFO to assembler.
    logic [`SPDIF_BYTE_W-1:0] fifo_data;
    logic                     fifo_empty;
    logic                     fifo_pop;

    // Assembler to encoder.
    spdif_pkg::subframe_u     sample_word;
    logic                     sample_ready;
    logic                     sample_take;

    // Byte buffer.
    byte_fifo u_fifo (
        .byte_clk_i (byte_clk_i),
        .reset_i    (reset_i),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .rd_en_i    (fifo_pop),
        .rd_data_o  (fifo_data),
        .full_o     (full_o),
        .empty_o    (fifo_empty)
    );

    // Bytes into sub-frame words.
    sample_assembler u_assembler (
        .byte_clk_i     (byte_clk_i),
        .reset_i        (reset_i),
        .bit_depth_i    (bit_depth_i),
        .fifo_data_i    (fifo_data),
        .fifo_empty_i   (fifo_empty),
        .fifo_pop_o     (fifo_pop),
        .sample_take_i  (sample_take),
        .sample_word_o  (sample_word),
        .sample_ready_o (sample_ready)
    );

    // Words onto the line.
    biphase_encoder u_encoder (
        .byte_clk_i     (byte_clk_i),
        .reset_i        (reset_i),
        .sample_word_i  (sample_word),
        .sample_ready_i (sample_ready),
        .sample_take_o  (sample_take),
        .streaming_o    (streaming_o),
        .spdif_o        (spdif_o)
    );

endmodule

//--- logic/biphase_encoder.sv
`timescale 1ns/10ps

`include "spdif_defines.svh"

module biphase_encoder (
    input  logic                 byte_clk_i,
    input  logic                 reset_i,
    // Assembler side.
    input  spdif_pkg::subframe_u sample_word_i,
    input  logic                 sample_ready_i,
    output logic                 sample_take_o,
    // Line side.
    output logic                 streaming_o,
    output logic                 spdif_o
);

    localparam logic [5:0] LAST_CELL = 6'(`SPDIF_CELLS - 1);
    localparam logic [8:0] LAST_SF   = 9'(`SPDIF_BLOCK_SUBFRAMES - 1);
    localparam logic [5:0] PRE_CELLS = 6'd8;

    // Cell now on the line, 0..63.
    logic [5:0] cell_q;
    // Sub-frame now on the line, 0..383.
    logic [8:0] sf_q;
    logic       streaming_q;
    logic       spdif_q;

    // Remaining preamble cells 1..7, already level-corrected.
    logic [6:0] pre_q;
    // Word being sent.
    spdif_pkg::subframe_u word_q;

    logic       last_cell;
    logic       take;
    logic [8:0] next_sf;
    logic [7:0] pre_sel;
    logic [5:0] next_cell;
    logic [4:0] data_idx;
    logic [4:0] raw_idx;
    logic       data_bit;
    logic       next_level;

    // ==============================
    // Sub-frame sequencing
    // ==============================

    assign last_cell = (cell_q == LAST_CELL);

    // Start from idle, or chain on the last cell with no gap.
    assign take = sample_ready_i & (~streaming_q | last_cell);

    // A fresh stream always opens a block.
    always_comb begin
        if (!streaming_q || sf_q == LAST_SF) begin
            next_sf = 9'd0;
        end else begin
            next_sf = sf_q + 9'd1;
        end
    end

    // B opens the block, then left gets M and right gets W.
    always_comb begin
        if (next_sf == 9'd0) begin
            pre_sel = `SPDIF_PRE_B;
        end else if (next_sf[0]) begin
            pre_sel = `SPDIF_PRE_W;
        end else begin
            pre_sel = `SPDIF_PRE_M;
        end
    end

    // ==============================
    // Line coding
    // ==============================

    assign next_cell = cell_q + 6'd1;

    // Data bit number 0..27 for cells 8..63.
    assign data_idx = next_cell[5:1] - 5'd4;

    // Audio goes LSB first from bit 8 up.
    // Then V, U, C and P from bit 7 down to bit 4.
    assign raw_idx  = (data_idx < 5'd24) ? (data_idx + 5'd8) : (5'd31 - data_idx);
    assign data_bit = word_q.raw[raw_idx];

    // Level of the next cell.
    always_comb begin
        if (next_cell < PRE_CELLS) begin
            next_level = pre_q[6];
        end else if (!next_cell[0]) begin
            // Every bit starts with a transition.
            next_level = ~spdif_q;
        end else begin
            // A one adds a mid-bit transition.
            next_level = spdif_q ^ data_bit;
        end
    end

    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            cell_q      <= 6'd0;
            sf_q        <= 9'd0;
            streaming_q <= 1'b0;
            spdif_q     <= 1'b1;
        end else if (take) begin
            // First preamble cell goes out on this edge.
            cell_q      <= 6'd0;
            sf_q        <= next_sf;
            streaming_q <= 1'b1;
            spdif_q     <= pre_sel[7] ^ spdif_q;
        end else if (streaming_q) begin
            if (last_cell) begin
                // Nothing ready, back to idle high.
                cell_q      <= 6'd0;
                sf_q        <= 9'd0;
                streaming_q <= 1'b0;
                spdif_q     <= 1'b1;
            end else begin
                cell_q  <= next_cell;
                spdif_q <= next_level;
            end
        end
    end

    // Word and preamble payload.
    // Preamble is inverted when the line was high before cell 0.
    always_ff @(posedge byte_clk_i) begin
        if (take) begin
            word_q <= sample_word_i;
            pre_q  <= pre_sel[6:0] ^ {7{spdif_q}};
        end else if (streaming_q && next_cell < PRE_CELLS) begin
            pre_q <= {pre_q[5:0], 1'b0};
        end
    end

    assign sample_take_o = take;
    assign streaming_o   = streaming_q;
    assign spdif_o       = spdif_q;

endmodule

//--- logic/sample_assembler.sv
`timescale 1ns/10ps

`include "spdif_defines.svh"

module sample_assembler (
    input  logic                     byte_clk_i,
    input  logic                     reset_i,
    // Depth code, 16 or 24 bits.
    input  logic [1:0]               bit_depth_i,
    // FIFO read side.
    input  logic [`SPDIF_BYTE_W-1:0] fifo_data_i,
    input  logic                     fifo_empty_i,
    output logic                     fifo_pop_o,
    // Encoder side.
    input  logic                     sample_take_i,
    output spdif_pkg::subframe_u     sample_word_o,
    output logic                     sample_ready_o
);

    localparam int AUDIO_W = 24;

    // Byte position inside the current sample.
    logic [1:0] byte_idx;
    // Held sample waiting for the encoder.
    logic       ready_q;

    // Audio shift register, newest byte at the bottom.
    logic [AUDIO_W-1:0] audio_q;
    // Running XOR over the audio bytes.
    logic               parity_q;

    logic depth_16;
    logic depth_ok;
    logic pop;
    logic last_byte;
    logic byte_parity;

    // ==============================
    // Byte intake
    // ==============================

    assign depth_16 = (bit_depth_i == `SPDIF_DEPTH_16);
    assign depth_ok = depth_16 | (bit_depth_i == `SPDIF_DEPTH_24);

    // One byte per clock, held off while a sample waits.
    // Unknown depth codes stall here.
    assign pop = depth_ok & ~fifo_empty_i & ~ready_q;

    // Two bytes at 16 bits, three at 24 bits.
    assign last_byte = (byte_idx == (depth_16 ? 2'd1 : 2'd2));

    assign byte_parity = ^fifo_data_i;

    assign fifo_pop_o     = pop;
    assign sample_ready_o = ready_q;

    // Control state.
    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            byte_idx <= 2'd0;
            ready_q  <= 1'b0;
        end else begin
            // Encoder took the word, free the slot.
            if (sample_take_i) begin
                ready_q <= 1'b0;
            end
            if (pop) begin
                if (last_byte) begin
                    byte_idx <= 2'd0;
                    ready_q  <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 2'd1;
                end
            end
        end
    end

    // Sample payload.
    // MSB arrives first, so bytes shift up from the bottom.
    // The first byte clears the rest, which zeroes the top byte at 16 bits.
    always_ff @(posedge byte_clk_i) begin
        if (pop) begin
            if (byte_idx == 2'd0) begin
                audio_q  <= {{(AUDIO_W-`SPDIF_BYTE_W){1'b0}}, fifo_data_i};
                parity_q <= byte_parity;
            end else begin
                audio_q  <= {audio_q[AUDIO_W-`SPDIF_BYTE_W-1:0], fifo_data_i};
                parity_q <= parity_q ^ byte_parity;
            end
        end
    end

    // ==============================
    // Sub-frame word
    // ==============================

    // V, U and C stay zero.
    // Parity then only depends on the audio bits.
    always_comb begin
        sample_word_o.fields.audio          = audio_q;
        sample_word_o.fields.validity       = 1'b0;
        sample_word_o.fields.user           = 1'b0;
        sample_word_o.fields.channel_status = 1'b0;
        sample_word_o.fields.parity         = parity_q;
        sample_word_o.fields.pad            = 4'd0;
    end

endmodule

//--- logic/byte_fifo.sv
`timescale 1ns/10ps

`include "spdif_defines.svh"

module byte_fifo (
    input  logic                     byte_clk_i,
    input  logic                     reset_i,
    // Write side.
    input  logic                     wr_en_i,
    input  logic [`SPDIF_BYTE_W-1:0] wr_data_i,
    // Read side, show-ahead.
    input  logic                     rd_en_i,
    output logic [`SPDIF_BYTE_W-1:0] rd_data_o,
    // Status.
    output logic                     full_o,
    output logic                     empty_o
);

    localparam int DEPTH = 1 << `SPDIF_FIFO_AW;

    // Storage.
    logic [`SPDIF_BYTE_W-1:0] mem [DEPTH];

    // Pointers carry one extra wrap bit.
    logic [`SPDIF_FIFO_AW:0] wr_ptr;
    logic [`SPDIF_FIFO_AW:0] rd_ptr;

    logic do_write;
    logic do_read;

    // ==============================
    // Flags
    // ==============================

    // Same address and same wrap bit means empty.
    assign empty_o = (wr_ptr == rd_ptr);

    // Same address and opposite wrap bit means full.
    assign full_o = (wr_ptr[`SPDIF_FIFO_AW] != rd_ptr[`SPDIF_FIFO_AW]) &&
                    (wr_ptr[`SPDIF_FIFO_AW-1:0] == rd_ptr[`SPDIF_FIFO_AW-1:0]);

    // Writes while full and reads while empty are dropped.
    assign do_write = wr_en_i & ~full_o;
    assign do_read  = rd_en_i & ~empty_o;

    // Oldest byte is always on the output.
    assign rd_data_o = mem[rd_ptr[`SPDIF_FIFO_AW-1:0]];

    // ==============================
    // Pointers and storage
    // ==============================

    always_ff @(posedge byte_clk_i or posedge reset_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Pop takes effect at this edge.
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Byte storage.
    always_ff @(posedge byte_clk_i) begin
        if (do_write) begin
            mem[wr_ptr[`SPDIF_FIFO_AW-1:0]] <= wr_data_i;
        end
    end

endmodule

//--- logic/spdif_pkg.sv
`include "spdif_defines.svh"

package spdif_pkg;

    // ==============================
    // Sub-frame word
    // ==============================

    // Field view of one sub-frame word.
    // Audio sits in bits 31..8, LSB at bit 8.
    typedef struct packed {
        logic [23:0] audio;
        logic        validity;
        logic        user;
        logic        channel_status;
        logic        parity;
        logic [3:0]  pad;
    } subframe_fields_t;

    // The assembler builds the word by field.
    // The encoder walks it by bit index.
    typedef union packed {
        logic [`SPDIF_WORD_W-1:0] raw;
        subframe_fields_t         fields;
    } subframe_u;

endpackage

//--- logic/spdif_defines.svh
`ifndef SPDIF_DEFINES_SVH
`define SPDIF_DEFINES_SVH

// ==============================
// Data path widths
// ==============================

// One audio byte as written by the host.
`define SPDIF_BYTE_W 8
// One sub-frame word, audio plus status bits.
`define SPDIF_WORD_W 32
// FIFO address width, depth is 2**AW.
`define SPDIF_FIFO_AW 4

// Bit depth codes on bit_depth_i.
// Codes 2 and 3 are not accepted and stall the assembler.
`define SPDIF_DEPTH_16 2'd0
`define SPDIF_DEPTH_24 2'd1

// ==============================
// Line format
// ==============================

// Half-bit cells in one sub-frame.
`define SPDIF_CELLS 64
// Sub-frames in one block, 192 frames.
`define SPDIF_BLOCK_SUBFRAMES 384

// Preambles, cell 0 in bit 7, as sent after a low line.
// The encoder inverts them after a high line.
`define SPDIF_PRE_B 8'b11101000
`define SPDIF_PRE_M 8'b11100010
`define SPDIF_PRE_W 8'b11100100

`endif
